/* files.f */
+incdir+sim
hw/stream_geom_pkg.sv
hw/bedrock_msg_pkg.sv
hw/lite_msg_decode.sv
hw/stream_beat_sequencer.sv
hw/stream_beat_emit.sv
hw/lite_to_stream_top.sv
sim/tb_lite_to_stream.sv

/* hw/bedrock_msg_pkg.sv */
package bedrock_msg_pkg;

  // message types on the memory port
  typedef enum logic [3:0] {
    // cached read
    e_rd = 4'd0,
    // cached write
    e_wr = 4'd1,
    // uncached read
    e_uc_rd = 4'd2,
    // uncached write
    e_uc_wr = 4'd3,
    // atomic op, carries an operand
    e_amo = 4'd4,
    // invalidate
    e_inv = 4'd5
  } msg_type_e;

  // message header, 47 bits
  typedef struct packed {
    // kind of request
    msg_type_e msg_type;
    // log2 of the byte count
    logic [2:0] size;
    // physical address of the access
    logic [stream_geom_pkg::paddr_width-1:0] addr;
    // requester id
    logic [7:0] payload;
  } msg_header_s;

  // lite message, header plus one full data word
  typedef struct packed {
    msg_header_s header;
    logic [stream_geom_pkg::lite_data_width-1:0] data;
  } lite_msg_s;

endpackage

/* hw/lite_msg_decode.sv */
`timescale 1ns/10ps

module lite_msg_decode
  #(parameter logic [15:0] payload_mask_p = '0
  )
  (input logic clk_i
  , input logic arst_n_i

  , input bedrock_msg_pkg::lite_msg_s lite_msg_i
  , input logic capture_i

  , output bedrock_msg_pkg::msg_header_s held_header_o
  , output stream_geom_pkg::lite_data_u held_data_o
  , output logic [stream_geom_pkg::beat_idx_width:0] beat_count_o
  , output logic [stream_geom_pkg::beat_idx_width-1:0] first_idx_o
  );

  localparam int cnt_width_lp = stream_geom_pkg::beat_idx_width + 1;

  typedef logic [cnt_width_lp-1:0] cnt_t;

  bedrock_msg_pkg::msg_header_s header_r;
  stream_geom_pkg::lite_data_u data_r;
  logic has_payload;
  logic [7:0] byte_count;
  logic [7:0] raw_beats;

  // hold header and data for the rest of the burst
  always_ff @(posedge clk_i)
  begin
    if (capture_i)
    begin
      header_r <= lite_msg_i.header;
      data_r.word <= lite_msg_i.data;
    end
  end

  // live input in the capture cycle so beat 0 leaves at once
  always_comb
  begin
    if (capture_i)
    begin
      held_header_o = lite_msg_i.header;
      held_data_o.word = lite_msg_i.data;
    end
    else
    begin
      held_header_o = header_r;
      held_data_o = data_r;
    end
  end

  assign has_payload = payload_mask_p[held_header_o.msg_type];

  // 2^size bytes, then bytes per beat
  assign byte_count = 8'd1 << held_header_o.size;
  assign raw_beats = byte_count >> stream_geom_pkg::beat_offset_width;

  always_comb
  begin
    if (!has_payload || raw_beats == '0)
      beat_count_o = cnt_t'(1);
    else if (raw_beats > 8'(stream_geom_pkg::beats_per_msg))
      beat_count_o = cnt_t'(stream_geom_pkg::beats_per_msg);
    else
      beat_count_o = raw_beats[cnt_width_lp-1:0];
  end

  // starting beat comes from the address
  assign first_idx_o =
    held_header_o.addr[stream_geom_pkg::beat_offset_width +: stream_geom_pkg::beat_idx_width];

  // a payload request must fit in one lite word
  payload_fits_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    capture_i && has_payload |-> raw_beats <= 8'(stream_geom_pkg::beats_per_msg))
    else $error("payload message asks for more beats than one lite word holds");

endmodule

/* hw/lite_to_stream_top.sv */
`timescale 1ns/10ps

module lite_to_stream_top
  #(parameter logic [15:0] payload_mask_p = (16'd1 << bedrock_msg_pkg::e_wr)
                                          | (16'd1 << bedrock_msg_pkg::e_uc_wr)
                                          | (16'd1 << bedrock_msg_pkg::e_amo)
  )
  (input logic clk_i
  , input logic arst_n_i

  // lite side, ready-valid-and
  , input bedrock_msg_pkg::lite_msg_s lite_msg_i
  , input logic in_msg_v_i
  , output logic in_msg_ready_o

  // stream side, ready-valid-and
  , output bedrock_msg_pkg::msg_header_s out_header_o
  , output logic [stream_geom_pkg::beat_width-1:0] out_data_o
  , output logic out_v_o
  , input logic out_ready_i
  , output logic out_last_o
  );

  bedrock_msg_pkg::msg_header_s held_header;
  stream_geom_pkg::lite_data_u held_data;
  logic [stream_geom_pkg::beat_idx_width:0] beat_count;
  logic [stream_geom_pkg::beat_idx_width-1:0] first_idx;
  logic [stream_geom_pkg::beat_idx_width-1:0] beat_k;
  logic capture;
  logic out_v;
  logic last;

  lite_msg_decode
    #(.payload_mask_p(payload_mask_p))
    u_decode
    (.clk_i(clk_i)
    , .arst_n_i(arst_n_i)
    , .lite_msg_i(lite_msg_i)
    , .capture_i(capture)
    , .held_header_o(held_header)
    , .held_data_o(held_data)
    , .beat_count_o(beat_count)
    , .first_idx_o(first_idx)
    );

  stream_beat_sequencer u_seq
    (.clk_i(clk_i)
    , .arst_n_i(arst_n_i)
    , .in_msg_v_i(in_msg_v_i)
    , .in_msg_ready_o(in_msg_ready_o)
    , .out_ready_i(out_ready_i)
    , .beat_count_i(beat_count)
    , .capture_o(capture)
    , .beat_k_o(beat_k)
    , .out_v_o(out_v)
    , .last_o(last)
    );

  stream_beat_emit u_emit
    (.clk_i(clk_i)
    , .arst_n_i(arst_n_i)
    , .held_header_i(held_header)
    , .held_data_i(held_data)
    , .first_idx_i(first_idx)
    , .beat_k_i(beat_k)
    , .out_v_i(out_v)
    , .last_i(last)
    , .out_ready_i(out_ready_i)
    , .out_header_o(out_header_o)
    , .out_data_o(out_data_o)
    , .out_v_o(out_v_o)
    , .out_last_o(out_last_o)
    );

endmodule

/* hw/stream_beat_emit.sv */
`timescale 1ns/10ps

module stream_beat_emit
  (input logic clk_i
  , input logic arst_n_i

  , input bedrock_msg_pkg::msg_header_s held_header_i
  , input stream_geom_pkg::lite_data_u held_data_i
  , input logic [stream_geom_pkg::beat_idx_width-1:0] first_idx_i
  , input logic [stream_geom_pkg::beat_idx_width-1:0] beat_k_i
  , input logic out_v_i
  , input logic last_i
  , input logic out_ready_i

  , output bedrock_msg_pkg::msg_header_s out_header_o
  , output logic [stream_geom_pkg::beat_width-1:0] out_data_o
  , output logic out_v_o
  , output logic out_last_o
  );

  logic [stream_geom_pkg::beat_idx_width-1:0] beat_idx;

  // wraps within the lite word
  assign beat_idx = first_idx_i + beat_k_i;

  // address advances with the beat, other fields unchanged
  always_comb
  begin
    out_header_o = held_header_i;
    out_header_o.addr[stream_geom_pkg::beat_offset_width +: stream_geom_pkg::beat_idx_width] =
      beat_idx;
  end

  // data is taken in order from beat 0
  assign out_data_o = held_data_i.beats[beat_k_i];

  assign out_v_o = out_v_i;
  assign out_last_o = out_v_i & last_i;

  // stalled beat must not change under back-pressure
  hold_under_stall_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    out_v_o && !out_ready_i |=>
      out_v_o && $stable(out_header_o) && $stable(out_data_o) && $stable(out_last_o))
    else $error("stream beat changed while stalled");

endmodule

/* hw/stream_beat_sequencer.sv */
`timescale 1ns/10ps

module stream_beat_sequencer
  (input logic clk_i
  , input logic arst_n_i

  // lite side handshake
  , input logic in_msg_v_i
  , output logic in_msg_ready_o

  // stream side ready
  , input logic out_ready_i

  // beats in the current message
  , input logic [stream_geom_pkg::beat_idx_width:0] beat_count_i

  , output logic capture_o
  , output logic [stream_geom_pkg::beat_idx_width-1:0] beat_k_o
  , output logic out_v_o
  , output logic last_o
  );

  typedef logic [stream_geom_pkg::beat_idx_width-1:0] idx_t;
  typedef logic [stream_geom_pkg::beat_idx_width:0] cnt_t;

  logic streaming_r;
  idx_t beat_k_r;
  logic beat_done;

  // no new message while a burst is in flight
  assign in_msg_ready_o = out_ready_i & ~streaming_r;
  assign capture_o = in_msg_v_i & in_msg_ready_o;

  // beat 0 goes out in the accept cycle
  assign out_v_o = streaming_r | capture_o;

  // counter reads as 0 while capturing
  assign beat_k_o = streaming_r ? beat_k_r : '0;

  assign last_o = (cnt_t'(beat_k_o) == beat_count_i - cnt_t'(1));
  assign beat_done = out_v_o & out_ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      streaming_r <= 1'b0;
      beat_k_r <= '0;
    end
    else if (beat_done)
    begin
      if (last_o)
      begin
        // burst finished or single beat message
        streaming_r <= 1'b0;
        beat_k_r <= '0;
      end
      else
      begin
        streaming_r <= 1'b1;
        beat_k_r <= beat_k_o + idx_t'(1);
      end
    end
  end

  // counter stays inside the message length
  beat_in_range_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    out_v_o |-> cnt_t'(beat_k_o) < beat_count_i)
    else $error("beat counter ran past the message length");

endmodule

/* hw/stream_geom_pkg.sv */
package stream_geom_pkg;

  // width of the lite data word
  parameter int lite_data_width = 64;

  // width of one stream beat
  parameter int beat_width = 16;

  // a full lite word splits into this many beats
  parameter int beats_per_msg = lite_data_width / beat_width;

  // beat number within a burst
  parameter int beat_idx_width = $clog2(beats_per_msg);

  // byte offset inside one beat
  parameter int beat_offset_width = $clog2(beat_width / 8);

  // physical address width
  parameter int paddr_width = 32;

  // the lite data word, read two ways
  // word is the flat view filled at capture
  // beats is the per-beat view used when streaming out
  typedef union packed {
    logic [lite_data_width-1:0] word;
    logic [beats_per_msg-1:0][beat_width-1:0] beats;
  } lite_data_u;

endpackage

/* run_sim.sh */
#!/bin/bash
# build and run the lite-to-stream bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  -f files.f \
  --top-module tb_lite_to_stream \
  -Mdir obj_dir \
  || { echo "build failed"; exit 1; }

./obj_dir/Vtb_lite_to_stream > sim.log 2>&1

cat sim.log

grep -qx "SIMULATION PASSED" sim.log && { echo "run passed"; exit 0; } \
  || { echo "run failed"; exit 1; }

/* sim/tb_stream_model.svh */
`ifndef TB_STREAM_MODEL_SVH
`define TB_STREAM_MODEL_SVH

// one expected stream beat
typedef struct packed {
  bedrock_msg_pkg::msg_header_s header;
  logic [15:0] data;
  logic last;
} exp_beat_s;

// writes and atomics carry data, everything else is header only
function automatic bit type_has_data(input bedrock_msg_pkg::msg_type_e msg_type);
  case (msg_type)
    bedrock_msg_pkg::e_wr,
    bedrock_msg_pkg::e_uc_wr,
    bedrock_msg_pkg::e_amo: return 1'b1;
    default: return 1'b0;
  endcase
endfunction

// 2^size bytes at two bytes per beat, never fewer than one beat
function automatic int beats_for(input bit has_data, input logic [2:0] size);
  int bytes;
  bytes = 1 << size;
  if (!has_data || bytes < 2)
    return 1;
  return bytes / 2;
endfunction

// expand one lite message into the beats the bridge should emit
task automatic expand_message(input bedrock_msg_pkg::lite_msg_s msg,
                              output exp_beat_s [3:0] beats,
                              output int n);
  logic [1:0] first_idx;
  n = beats_for(type_has_data(msg.header.msg_type), msg.header.size);
  first_idx = msg.header.addr[2:1];
  beats = '0;
  for (int k = 0; k < n; k++)
  begin
    beats[k].header = msg.header;
    // beat position wraps inside the 8-byte word
    beats[k].header.addr[2:1] = first_idx + 2'(k);
    beats[k].data = msg.data[16*k +: 16];
    beats[k].last = (k == n - 1);
  end
endtask

`endif

/* sim/tb_lite_to_stream.sv */
`timescale 1ns/10ps

module tb_lite_to_stream;

  localparam int num_msgs_lp = 200;
  localparam int clk_period_lp = 8;
  localparam int reset_cycles_lp = 10;
  // up to 4 beats of up to 8 cycles per message
  localparam int timeout_ns_lp =
    num_msgs_lp * 4 * 8 * clk_period_lp + reset_cycles_lp * clk_period_lp;

  `include "tb_stream_model.svh"

  logic clk_i;
  logic arst_n_i;
  bedrock_msg_pkg::lite_msg_s lite_msg_i;
  logic in_msg_v_i;
  logic in_msg_ready_o;
  bedrock_msg_pkg::msg_header_s out_header_o;
  logic [15:0] out_data_o;
  logic out_v_o;
  logic out_ready_i;
  logic out_last_o;

  integer seed;
  exp_beat_s exp_q[$];
  logic took_input = 1'b0;
  int launched = 0;
  int accepted = 0;
  int gap = 0;
  int errors = 0;
  int checks = 0;
  int tests = 0;
  int beat_no = 0;
  int err_base = 0;

  lite_to_stream_top i_lite_to_stream_top
    (.clk_i(clk_i)
    , .arst_n_i(arst_n_i)
    , .lite_msg_i(lite_msg_i)
    , .in_msg_v_i(in_msg_v_i)
    , .in_msg_ready_o(in_msg_ready_o)
    , .out_header_o(out_header_o)
    , .out_data_o(out_data_o)
    , .out_v_o(out_v_o)
    , .out_ready_i(out_ready_i)
    , .out_last_o(out_last_o)
    );

  always #(clk_period_lp / 2) clk_i = ~clk_i;

  task automatic report_test(input string what);
    tests++;
    $display("test %0d: %s %s", tests, what, (errors == err_base) ? "ok" : "with errors");
    err_base = errors;
  endtask

  task automatic check_beat(input exp_beat_s exp_beat);
    checks++;
    beat_no++;
    assert (out_header_o === exp_beat.header)
    else
    begin
      $display("FAILED out_header_o expected %h got %h", exp_beat.header, out_header_o);
      errors++;
    end
    assert (out_data_o === exp_beat.data)
    else
    begin
      $display("FAILED out_data_o expected %h got %h", exp_beat.data, out_data_o);
      errors++;
    end
    assert (out_last_o === exp_beat.last)
    else
    begin
      $display("FAILED out_last_o expected %h got %h", exp_beat.last, out_last_o);
      errors++;
    end
    if (exp_beat.last)
    begin
      report_test($sformatf("message of %0d beats", beat_no));
      beat_no = 0;
    end
  endtask

  function automatic bedrock_msg_pkg::lite_msg_s random_message();
    bedrock_msg_pkg::lite_msg_s msg;
    int t;
    t = $unsigned($random(seed)) % 6;
    msg.header.msg_type = bedrock_msg_pkg::msg_type_e'(t[3:0]);
    msg.header.size = 3'($random(seed) & 3);
    msg.header.addr = $random(seed);
    msg.header.payload = 8'($random(seed));
    msg.data = {$random(seed), $random(seed)};
    return msg;
  endfunction

  // one cycle of stimulus just after the rising edge
  task automatic drive_cycle();
    if (in_msg_v_i && took_input)
    begin
      in_msg_v_i = 1'b0;
      gap = $random(seed) & 3;
    end
    // ready high about three cycles in four
    out_ready_i = (($random(seed) & 3) != 0);
    if (!in_msg_v_i && launched < num_msgs_lp)
    begin
      if (gap == 0)
      begin
        lite_msg_i = random_message();
        in_msg_v_i = 1'b1;
        launched++;
      end
      else
        gap--;
    end
  endtask

  // sample mid-cycle where all DUT outputs have settled
  always @(negedge clk_i)
  begin : monitor
    exp_beat_s [3:0] beats;
    int n;
    logic exp_ready;
    logic exp_valid;
    took_input = in_msg_v_i && in_msg_ready_o;
    if (arst_n_i === 1'b1)
    begin
      // input side opens only between bursts
      exp_ready = out_ready_i && (exp_q.size() == 0);
      assert (in_msg_ready_o === exp_ready)
      else
      begin
        $display("FAILED in_msg_ready_o expected %h got %h", exp_ready, in_msg_ready_o);
        errors++;
      end
    end
    if (arst_n_i === 1'b1 && took_input)
    begin
      assert (exp_q.size() == 0)
      else
      begin
        $display("message %0d was accepted while the previous burst was still in progress",
                 accepted);
        errors++;
      end
      expand_message(lite_msg_i, beats, n);
      for (int k = 0; k < n; k++)
        exp_q.push_back(beats[k]);
      accepted++;
    end
    if (arst_n_i === 1'b1)
    begin
      // a beat is on offer whenever one is still owed
      exp_valid = (exp_q.size() != 0);
      assert (out_v_o === exp_valid)
      else
      begin
        $display("FAILED out_v_o expected %h got %h", exp_valid, out_v_o);
        errors++;
      end
    end
    if (arst_n_i === 1'b1 && out_v_o && out_ready_i)
    begin
      assert (exp_q.size() != 0)
      else
      begin
        $display("an output beat left the bridge with no beat expected");
        errors++;
      end
      if (exp_q.size() != 0)
        check_beat(exp_q.pop_front());
    end
  end

  initial
  begin
    seed = 32'h12fa;
    clk_i = 1'b0;
    arst_n_i = 1'b0;
    lite_msg_i = '0;
    in_msg_v_i = 1'b0;
    out_ready_i = 1'b0;
    repeat (reset_cycles_lp) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;
    @(negedge clk_i);
    assert (out_v_o === 1'b0)
    else
    begin
      $display("FAILED out_v_o expected %h got %h", 1'b0, out_v_o);
      errors++;
    end
    report_test("idle output after reset");
    while (accepted < num_msgs_lp || exp_q.size() != 0)
    begin
      @(posedge clk_i);
      #1;
      drive_cycle();
    end
    // a few idle cycles to catch stray beats
    in_msg_v_i = 1'b0;
    out_ready_i = 1'b1;
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    assert (exp_q.size() == 0 && out_v_o === 1'b0)
    else
    begin
      $display("bridge not idle after the last message, %0d beats still expected",
               exp_q.size());
      errors++;
    end
    report_test("drain after last message");
    $display("tests %0d, beat checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

  initial
  begin : watchdog
    #(timeout_ns_lp);
    $display("timeout, the run did not finish within %0d ns", timeout_ns_lp);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule
